//--- list.f
pwm_bus_pkg.sv
pwm_core_pkg.sv
periph_bus_if.sv
pwm_generator.sv
pwm_channel.sv
pwm_bank.sv
pwm_bank_properties.sv
tb_pwm_bank.sv

//--- periph_bus_if.sv
// peripheral bus interface: one channel's view of the processor's memory-mapped bus
interface periph_bus_if;

    logic                                select;    // bus enable from the top
    logic [pwm_bus_pkg::addr_width-1:0]  addr;
    logic [pwm_bus_pkg::data_width-1:0]  data_in;
    logic                                write_en;
    logic [pwm_bus_pkg::data_width-1:0]  data_out;  // zero when not addressed

    // bank side, fans the top-level bus out
    modport host (
        output select, addr, data_in, write_en,
        input  data_out
    );

    // channel side
    modport device (
        input  select, addr, data_in, write_en,
        output data_out
    );

endinterface

//--- pwm_bank.sv
// PWM bank: decodes one bus window holding channel_count PWM channels and merges their reads
module pwm_bank #(
    parameter logic [pwm_bus_pkg::addr_width-1:0] base_addr     = pwm_bus_pkg::default_base_addr,
    parameter int unsigned                        channel_count = 2
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                enable,
    input  logic [pwm_bus_pkg::addr_width-1:0]  addr,
    input  logic [pwm_bus_pkg::data_width-1:0]  data_in,
    input  logic                                write_en,
    output logic [pwm_bus_pkg::data_width-1:0]  data_out,
    output logic [channel_count-1:0]            pwm_out
);

    // read data of each channel, zero when not addressed
    logic [pwm_bus_pkg::data_width-1:0] chan_data [channel_count];

    for (genvar i = 0; i < channel_count; i++)
    begin : gen_chan
        // two registers per channel, packed one after the other
        localparam logic [pwm_bus_pkg::addr_width-1:0] chan_base =
            base_addr + pwm_bus_pkg::addr_width'(2 * i);

        periph_bus_if bus_if ();

        assign bus_if.select   = enable;
        assign bus_if.addr     = addr;
        assign bus_if.data_in  = data_in;
        assign bus_if.write_en = write_en;
        assign chan_data[i]    = bus_if.data_out;

        pwm_channel #(
            .base_addr (chan_base)
        ) i_pwm_channel (
            .clk     (clk),
            .reset   (reset),
            .bus     (bus_if.device),
            .pwm_out (pwm_out[i])
        );
    end

    // at most one channel matches, so an OR is enough as read mux
    always_comb
    begin
        data_out = '0;
        for (int k = 0; k < channel_count; k++)
        begin
            data_out = data_out | chan_data[k];
        end
    end

endmodule

//--- pwm_bank_properties.sv
// PWM bank properties: bus read quiet outside enable and window, outputs low after reset
module pwm_bank_properties #(
    parameter logic [pwm_bus_pkg::addr_width-1:0] base_addr     = pwm_bus_pkg::default_base_addr,
    parameter int unsigned                        channel_count = 2
) (
    input logic                                clk,
    input logic                                reset,
    input logic                                enable,
    input logic [pwm_bus_pkg::addr_width-1:0]  addr,
    input logic [pwm_bus_pkg::data_width-1:0]  data_out,
    input logic [channel_count-1:0]            pwm_out
);

    // window covers two registers per channel
    localparam int unsigned window_lo = int'(base_addr);
    localparam int unsigned window_hi = int'(base_addr) + 2 * channel_count;

    logic outside;

    assign outside = (32'(addr) < window_lo) || (32'(addr) >= window_hi);

    a_quiet_when_disabled: assert property (@(posedge clk) !enable |-> data_out == '0)
        else $error("data_out not zero while enable is low");

    a_out_low_after_reset: assert property (@(posedge clk) !reset |=> pwm_out == '0)
        else $error("pwm_out not low in the cycle after reset");

    a_quiet_outside_window: assert property (@(posedge clk) outside |-> data_out == '0)
        else $error("data_out not zero for an address outside the window");

endmodule

//--- pwm_bus_pkg.sv
// peripheral bus package: bus widths, default window base and register select codes
package pwm_bus_pkg;

    localparam int addr_width = 16;     // processor address space
    localparam int data_width = 8;      // bus data and register width

    // first address of the PWM window on the peripheral bus
    localparam logic [addr_width-1:0] default_base_addr = 16'hFF1A;

    // register offset inside one channel's two-address window
    typedef enum logic [0:0] {
        reg_period = 1'b0,              // counter wrap value
        reg_duty   = 1'b1               // high cycles per period
    } reg_sel_e;

endpackage

//--- pwm_channel.sv
// PWM channel with period and duty registers on the peripheral bus driving one generator
module pwm_channel #(
    parameter logic [pwm_bus_pkg::addr_width-1:0] base_addr = pwm_bus_pkg::default_base_addr
) (
    input  logic         clk,
    input  logic         reset,
    periph_bus_if.device bus,
    output logic         pwm_out
);

    logic [pwm_bus_pkg::addr_width-1:0] addr_offset;
    logic                               hit;
    pwm_bus_pkg::reg_sel_e              reg_sel;

    logic [pwm_bus_pkg::data_width-1:0] period_reg;
    logic [pwm_bus_pkg::data_width-1:0] duty_reg;

    // addresses below base wrap to a large offset and miss
    assign addr_offset = bus.addr - base_addr;
    assign hit         = bus.select && (addr_offset < 2);
    assign reg_sel     = pwm_bus_pkg::reg_sel_e'(addr_offset[0]);

    // register writes at the clock edge
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            period_reg <= '0;
            duty_reg   <= '0;
        end
        else if (hit && bus.write_en)
        begin
            case (reg_sel)
                pwm_bus_pkg::reg_period: period_reg <= bus.data_in;
                pwm_bus_pkg::reg_duty:   duty_reg   <= bus.data_in;
            endcase
        end
    end

    // combinational read is zero unless this channel is addressed
    always_comb
    begin
        bus.data_out = '0;
        if (hit)
        begin
            case (reg_sel)
                pwm_bus_pkg::reg_period: bus.data_out = period_reg;
                pwm_bus_pkg::reg_duty:   bus.data_out = duty_reg;
            endcase
        end
    end

    pwm_generator i_pwm_generator (
        .clk        (clk),
        .reset      (reset),
        .period_max (period_reg),
        .duty       (duty_reg),
        .pwm_out    (pwm_out)
    );

endmodule

//--- pwm_core_pkg.sv
// PWM core package: counter width and generator output modes
package pwm_core_pkg;

    // counter runs over the full register range
    localparam int count_width = pwm_bus_pkg::data_width;

    // output mode, derived from duty against period
    //   mode_off  - duty is zero, output held low
    //   mode_run  - duty within 1..period, normal PWM
    //   mode_full - duty above period, output held high
    typedef enum logic [1:0] {
        mode_off  = 2'd0,
        mode_run  = 2'd1,
        mode_full = 2'd2
    } pwm_mode_e;

endpackage

//--- pwm_generator.sv
// PWM generator: period counter with change restart, mode decode and registered output
module pwm_generator (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [pwm_core_pkg::count_width-1:0] period_max,
    input  logic [pwm_core_pkg::count_width-1:0] duty,
    output logic                                 pwm_out
);

    pwm_core_pkg::pwm_mode_e mode;

    logic [pwm_core_pkg::count_width-1:0] count;
    logic [pwm_core_pkg::count_width-1:0] prev_period;
    logic [pwm_core_pkg::count_width-1:0] prev_duty;
    logic                                 changed;
    logic                                 out_next;

    // mode from the current register values
    always_comb
    begin
        if (duty == '0)
        begin
            mode = pwm_core_pkg::mode_off;
        end
        else if (duty > period_max)
        begin
            mode = pwm_core_pkg::mode_full;  // never reaches duty, stay high
        end
        else
        begin
            mode = pwm_core_pkg::mode_run;
        end
    end

    // inputs one cycle back, for change detection
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            prev_period <= '0;
            prev_duty   <= '0;
        end
        else
        begin
            prev_period <= period_max;
            prev_duty   <= duty;
        end
    end

    assign changed = (period_max != prev_period) || (duty != prev_duty);

    // counter runs 0..period_max, so one period is period_max + 1 cycles
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (changed || count == period_max)
        begin
            count <= '0;                     // restart after a register write
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    always_comb
    begin
        case (mode)
            pwm_core_pkg::mode_full: out_next = 1'b1;
            pwm_core_pkg::mode_run:  out_next = (count < duty);  // duty cycles high
            default:                 out_next = 1'b0;
        endcase
    end

    // registered output, lags the mode by one cycle
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            pwm_out <= 1'b0;
        end
        else
        begin
            pwm_out <= out_next;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the PWM bank testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_pwm_bank -f list.f -o sim_tb_pwm_bank; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_pwm_bank > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$log_file"; then
    exit 0
fi
echo "pass line not found in $log_file"
exit 1

//--- tb_pwm_bank.sv
// testbench for the PWM bank: register access over the bus and measured duty ratios
module tb_pwm_bank;

    localparam int          clk_period    = 8;
    localparam int          channel_count = 2;
    localparam logic [15:0] base          = pwm_bus_pkg::default_base_addr;
    localparam int          meas_cycles   = 3 * 256 + 8;   // worst case settle plus one window
    localparam int          meas_total    = 16;
    localparam int          timeout       = (meas_total * meas_cycles + 400) * clk_period * 2;

    logic                     clk;
    logic                     reset;
    logic                     enable;
    logic [15:0]              addr;
    logic [7:0]               data_in;
    logic                     write_en;
    logic [7:0]               data_out;
    logic [channel_count-1:0] pwm_out;

    int seed;
    int error_count;
    int check_count;
    int test_count;
    int test_start_errors;

    // request handed to the comparing process
    int         meas_chan;
    logic [7:0] meas_period;
    logic [7:0] meas_duty;
    event       meas_start;
    event       meas_done;

    pwm_bank i_pwm_bank (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .data_in  (data_in),
        .write_en (write_en),
        .data_out (data_out),
        .pwm_out  (pwm_out)
    );

    bind pwm_bank pwm_bank_properties #(
        .base_addr     (base_addr),
        .channel_count (channel_count)
    ) i_pwm_bank_properties (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .data_out (data_out),
        .pwm_out  (pwm_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // high cycles in one period window
    function automatic int expected_high(input logic [7:0] period, input logic [7:0] duty);
        if (duty == 8'd0)
            return 0;
        else if (duty > period)
            return int'(period) + 1;   // full mode
        return int'(duty);
    endfunction

    // all bus tasks start and end 1 unit after a rising edge
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        @(posedge clk);
        #1;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        enable = 1'b1;
        addr   = a;
        @(negedge clk);
        d = data_out;                  // combinational read, stable mid-cycle
        @(posedge clk);
        #1;
        enable = 1'b0;
    endtask

    task automatic read_check(input logic [15:0] a, input logic [7:0] exp);
        logic [7:0] got;
        bus_read(a, got);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] data_out at 0x%04h: got 0x%02h, expected 0x%02h", a, got, exp);
        end
    endtask

    task automatic set_channel(input int chan, input logic [7:0] p, input logic [7:0] d);
        bus_write(base + 16'(2 * chan), p);
        bus_write(base + 16'(2 * chan + 1), d);
    endtask

    task automatic measure(input int chan, input logic [7:0] p, input logic [7:0] d);
        meas_chan   = chan;
        meas_period = p;
        meas_duty   = d;
        -> meas_start;
        @(meas_done);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (error_count == test_start_errors) ? "ok" : "errors");
        test_start_errors = error_count;
    endtask

    // comparing process, counts high cycles once the counter has settled
    initial
    begin
        int high_count;
        int exp_count;
        forever
        begin
            @(meas_start);
            exp_count = expected_high(meas_period, meas_duty);
            repeat (2 * (int'(meas_period) + 1) + 4) @(posedge clk);
            high_count = 0;
            repeat (int'(meas_period) + 1)
            begin
                @(negedge clk);
                if (pwm_out[meas_chan] === 1'b1)
                    high_count++;
            end
            check_count++;
            if (high_count != exp_count)
            begin
                error_count++;
                $display("[ERROR] pwm_out[%0d] high cycles: got 0x%0h, expected 0x%0h",
                         meas_chan, high_count, exp_count);
            end
            -> meas_done;
        end
    end

    initial
    begin
        #(timeout);
        $display("timeout: tests did not finish within %0d time units", timeout);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        logic [7:0] shadow [4];
        logic [7:0] p;
        logic [7:0] d;
        seed              = 18177;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        test_start_errors = 0;
        reset    = 1'b0;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b1;

        // reset state
        for (int a = 0; a < 2 * channel_count; a++)
            read_check(base + 16'(a), 8'h00);
        repeat (20)
        begin
            @(negedge clk);
            check_count++;
            if (pwm_out !== '0)
            begin
                error_count++;
                $display("[ERROR] pwm_out: got 0x%0h, expected 0x0", pwm_out);
            end
        end
        @(posedge clk);
        #1;
        finish_test("reset state");

        // read-back, then accesses just outside the window
        for (int a = 0; a < 2 * channel_count; a++)
        begin
            shadow[a] = 8'($random(seed));
            bus_write(base + 16'(a), shadow[a]);
            read_check(base + 16'(a), shadow[a]);
        end
        read_check(base - 16'd1, 8'h00);
        read_check(base + 16'd4, 8'h00);
        bus_write(base + 16'd4, 8'($random(seed)));
        bus_write(base - 16'd1, 8'($random(seed)));
        read_check(base + 16'd4, 8'h00);
        for (int a = 0; a < 2 * channel_count; a++)
            read_check(base + 16'(a), shadow[a]);
        finish_test("register read-back");

        // edge modes, period kept below 255 so duty can exceed it
        for (int c = 0; c < channel_count; c++)
        begin
            p = 8'($random(seed)) % 8'd255;
            set_channel(c, p, 8'd0);
            measure(c, p, 8'd0);
            set_channel(c, p, p + 8'd1);
            measure(c, p, p + 8'd1);
        end
        finish_test("edge modes");

        for (int c = 0; c < channel_count; c++)
        begin
            for (int n = 0; n < 4; n++)
            begin
                p = 8'($random(seed));
                d = 8'(($random(seed) & 32'h7fff_ffff) % (int'(p) + 2));
                set_channel(c, p, d);
                measure(c, p, d);
            end
        end
        finish_test("duty ratio");

        // channel independence
        set_channel(0, 8'd40, 8'd13);
        set_channel(1, 8'd99, 8'd70);
        measure(0, 8'd40, 8'd13);
        measure(1, 8'd99, 8'd70);
        set_channel(1, 8'd20, 8'd5);
        measure(0, 8'd40, 8'd13);      // untouched by the rewrite
        measure(1, 8'd20, 8'd5);
        finish_test("channel independence");

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
